// File: logic/axil_reg_settings.svh
`ifndef AXIL_REG_SETTINGS_SVH
`define AXIL_REG_SETTINGS_SVH

// AXI4-Lite bus widths
`define AXIL_DATA_W 32
`define AXIL_ADDR_W 12

// One strobe bit per data byte
`define AXIL_STRB_W (`AXIL_DATA_W / 8)

// Words in the register bank
`define REG_COUNT 16

`endif

// File: logic/axil_reg_pkg.sv
`include "axil_reg_settings.svh"

package axil_reg_pkg;

  // AXI response codes
  typedef enum logic [1:0] {
    e_resp_okay   = 2'b00,
    e_resp_exokay = 2'b01,
    e_resp_slverr = 2'b10,
    e_resp_decerr = 2'b11
  } axi_resp_e;

  // AxPROT bit 0 marks privileged, bit 1 nonsecure and bit 2 instruction access
  typedef enum logic [2:0] {
    e_prot_data_sec_unpriv    = 3'b000,
    e_prot_data_sec_priv      = 3'b001,
    e_prot_data_nonsec_unpriv = 3'b010,
    e_prot_data_nonsec_priv   = 3'b011,
    e_prot_inst_sec_unpriv    = 3'b100,
    e_prot_inst_sec_priv      = 3'b101,
    e_prot_inst_nonsec_unpriv = 3'b110,
    e_prot_inst_nonsec_priv   = 3'b111
  } axi_prot_e;

  // Client FSM states
  typedef enum logic [1:0] {
    e_wait     = 2'b00,
    e_read_rx  = 2'b01,
    e_write_rx = 2'b10
  } client_state_e;

  // Plain request toward the register bank
  typedef struct packed {
    logic                    write;
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [`AXIL_STRB_W-1:0] wmask;
    logic [`AXIL_DATA_W-1:0] data;
  } reg_req_s;

endpackage

// File: logic/one_slot_fifo.sv
`timescale 1ns/10ps

module one_slot_fifo #(
  parameter int width_p = 8
) (
  input  logic               clk_i,
  input  logic               reset_i,

  input  logic [width_p-1:0] data_i,
  input  logic               v_i,
  output logic               ready_o,

  output logic [width_p-1:0] data_o,
  output logic               v_o,
  input  logic               yumi_i
);

  logic               full_r;
  logic [width_p-1:0] data_r;

  // Accept only into an empty slot
  assign ready_o = ~full_r;
  assign v_o     = full_r;
  assign data_o  = data_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      full_r <= 1'b0;
    end else if (v_i && ready_o) begin
      full_r <= 1'b1;
    end else if (yumi_i) begin
      full_r <= 1'b0;
    end
  end

  // Payload captured on each accepted transfer
  always_ff @(posedge clk_i) begin
    if (v_i && ready_o) begin
      data_r <= data_i;
    end
  end

  // Consumer may only dequeue what is actually held
  yumi_needs_data_a : assert property (
    @(posedge clk_i) disable iff (reset_i) yumi_i |-> full_r
  ) else $error("one_slot_fifo: yumi_i while slot empty");

endmodule

// File: logic/axil_fifo_client.sv
`timescale 1ns/10ps
`include "axil_reg_settings.svh"

module axil_fifo_client
  import axil_reg_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,

  // Request stream toward the register bank
  output reg_req_s                req_o,
  output logic                    req_v_o,
  input  logic                    req_ready_and_i,

  // Response stream from the register bank
  input  logic [`AXIL_DATA_W-1:0] rsp_data_i,
  input  logic                    rsp_v_i,
  output logic                    rsp_ready_and_o,

  // Write address
  input  logic [`AXIL_ADDR_W-1:0] s_axil_awaddr_i,
  input  axi_prot_e               s_axil_awprot_i,
  input  logic                    s_axil_awvalid_i,
  output logic                    s_axil_awready_o,

  // Write data
  input  logic [`AXIL_DATA_W-1:0] s_axil_wdata_i,
  input  logic [`AXIL_STRB_W-1:0] s_axil_wstrb_i,
  input  logic                    s_axil_wvalid_i,
  output logic                    s_axil_wready_o,

  // Write response
  output axi_resp_e               s_axil_bresp_o,
  output logic                    s_axil_bvalid_o,
  input  logic                    s_axil_bready_i,

  // Read address
  input  logic [`AXIL_ADDR_W-1:0] s_axil_araddr_i,
  input  axi_prot_e               s_axil_arprot_i,
  input  logic                    s_axil_arvalid_i,
  output logic                    s_axil_arready_o,

  // Read data
  output logic [`AXIL_DATA_W-1:0] s_axil_rdata_o,
  output axi_resp_e               s_axil_rresp_o,
  output logic                    s_axil_rvalid_o,
  input  logic                    s_axil_rready_i
);

  localparam int offset_w = $clog2(`AXIL_STRB_W);

  client_state_e state_r, state_n;

  logic [`AXIL_ADDR_W-1:0] ar_addr;
  logic [`AXIL_ADDR_W-1:0] ar_addr_aligned;
  logic                    ar_v;
  logic                    ar_yumi;

  logic [`AXIL_ADDR_W-1:0] aw_addr;
  logic                    aw_v;

  logic [`AXIL_DATA_W-1:0] w_data;
  logic [`AXIL_STRB_W-1:0] w_strb;
  logic                    w_v;

  // AW and W leave together
  logic                    wr_yumi;

  // Protection bits are ignored and every transfer is answered OKAY
  assign s_axil_bresp_o = e_resp_okay;
  assign s_axil_rresp_o = e_resp_okay;

  one_slot_fifo #(.width_p(`AXIL_ADDR_W)) ar_slot (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .data_i (s_axil_araddr_i),
    .v_i    (s_axil_arvalid_i),
    .ready_o(s_axil_arready_o),
    .data_o (ar_addr),
    .v_o    (ar_v),
    .yumi_i (ar_yumi)
  );

  one_slot_fifo #(.width_p(`AXIL_ADDR_W)) aw_slot (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .data_i (s_axil_awaddr_i),
    .v_i    (s_axil_awvalid_i),
    .ready_o(s_axil_awready_o),
    .data_o (aw_addr),
    .v_o    (aw_v),
    .yumi_i (wr_yumi)
  );

  one_slot_fifo #(.width_p(`AXIL_STRB_W + `AXIL_DATA_W)) w_slot (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .data_i ({s_axil_wstrb_i, s_axil_wdata_i}),
    .v_i    (s_axil_wvalid_i),
    .ready_o(s_axil_wready_o),
    .data_o ({w_strb, w_data}),
    .v_o    (w_v),
    .yumi_i (wr_yumi)
  );

  // Reads drop the byte offset within the bus word
  assign ar_addr_aligned = {ar_addr[`AXIL_ADDR_W-1:offset_w], {offset_w{1'b0}}};

  // Only one transfer in flight, so issue from WAIT only
  assign req_v_o = (state_r == e_wait) && (ar_v || (aw_v && w_v));

  // A pending read always wins over a complete write
  assign ar_yumi = req_v_o && req_ready_and_i && ar_v;
  assign wr_yumi = req_v_o && req_ready_and_i && !ar_v;

  always_comb begin
    req_o.write = ~ar_v;
    req_o.addr  = ar_v ? ar_addr_aligned : aw_addr;
    req_o.wmask = ar_v ? '0 : w_strb;
    req_o.data  = w_data;
  end

  always_comb begin
    state_n = state_r;
    case (state_r)
      e_wait: begin
        if (ar_yumi) begin
          state_n = e_read_rx;
        end else if (wr_yumi) begin
          state_n = e_write_rx;
        end
      end
      e_read_rx, e_write_rx: begin
        if (rsp_v_i && rsp_ready_and_o) begin
          state_n = e_wait;
        end
      end
      default: state_n = e_wait;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_wait;
    end else begin
      state_r <= state_n;
    end
  end

  // Response goes straight through to R or B
  assign rsp_ready_and_o = ((state_r == e_read_rx) && s_axil_rready_i)
                        || ((state_r == e_write_rx) && s_axil_bready_i);

  assign s_axil_rdata_o  = rsp_data_i;
  assign s_axil_rvalid_o = (state_r == e_read_rx) && rsp_v_i;
  assign s_axil_bvalid_o = (state_r == e_write_rx) && rsp_v_i;

  // The bank only answers a request that is in flight
  rsp_in_flight_a : assert property (
    @(posedge clk_i) disable iff (reset_i) rsp_v_i |-> (state_r != e_wait)
  ) else $error("axil_fifo_client: response from the bank with no request in flight");

endmodule

// File: logic/reg_bank.sv
`timescale 1ns/10ps
`include "axil_reg_settings.svh"

module reg_bank
  import axil_reg_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,

  input  reg_req_s                req_i,
  input  logic                    req_v_i,
  output logic                    req_ready_and_o,

  output logic [`AXIL_DATA_W-1:0] rsp_data_o,
  output logic                    rsp_v_o,
  input  logic                    rsp_ready_and_i
);

  localparam int offset_w = $clog2(`AXIL_STRB_W);
  localparam int index_w  = $clog2(`REG_COUNT);

  logic [`AXIL_DATA_W-1:0] regs_r [`REG_COUNT];
  logic [index_w-1:0]      index;
  logic [`AXIL_DATA_W-1:0] merged;
  logic                    req_take;
  logic                    rsp_v_r;
  logic [`AXIL_DATA_W-1:0] rsp_data_r;

  // Low word bits only; upper address bits alias
  assign index = req_i.addr[offset_w +: index_w];

  // New word with masked bytes replaced
  always_comb begin
    merged = regs_r[index];
    for (int b = 0; b < `AXIL_STRB_W; b++) begin
      if (req_i.wmask[b]) begin
        merged[b*8 +: 8] = req_i.data[b*8 +: 8];
      end
    end
  end

  // Hold off new work until the response is gone
  assign req_ready_and_o = ~rsp_v_r;
  assign req_take        = req_v_i && req_ready_and_o;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs_r[i] <= '0;
      end
    end else if (req_take && req_i.write) begin
      regs_r[index] <= merged;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rsp_v_r <= 1'b0;
    end else if (req_take) begin
      rsp_v_r <= 1'b1;
    end else if (rsp_ready_and_i) begin
      rsp_v_r <= 1'b0;
    end
  end

  // Write echoes the updated word, read returns the stored one
  always_ff @(posedge clk_i) begin
    if (req_take) begin
      rsp_data_r <= req_i.write ? merged : regs_r[index];
    end
  end

  assign rsp_v_o    = rsp_v_r;
  assign rsp_data_o = rsp_data_r;

  // A stalled request must not switch between read and write
  stable_dir_a : assert property (
    @(posedge clk_i) disable iff (reset_i)
    (req_v_i && !req_ready_and_o) |=> (!req_v_i || $stable(req_i.write))
  ) else $error("reg_bank: request direction changed while stalled");

endmodule

// File: logic/axil_reg_top.sv
`timescale 1ns/10ps
`include "axil_reg_settings.svh"

module axil_reg_top
  import axil_reg_pkg::*;
(
  input  logic                    clk_i,
  input  logic                    reset_i,

  input  logic [`AXIL_ADDR_W-1:0] s_axil_awaddr_i,
  input  axi_prot_e               s_axil_awprot_i,
  input  logic                    s_axil_awvalid_i,
  output logic                    s_axil_awready_o,

  input  logic [`AXIL_DATA_W-1:0] s_axil_wdata_i,
  input  logic [`AXIL_STRB_W-1:0] s_axil_wstrb_i,
  input  logic                    s_axil_wvalid_i,
  output logic                    s_axil_wready_o,

  output axi_resp_e               s_axil_bresp_o,
  output logic                    s_axil_bvalid_o,
  input  logic                    s_axil_bready_i,

  input  logic [`AXIL_ADDR_W-1:0] s_axil_araddr_i,
  input  axi_prot_e               s_axil_arprot_i,
  input  logic                    s_axil_arvalid_i,
  output logic                    s_axil_arready_o,

  output logic [`AXIL_DATA_W-1:0] s_axil_rdata_o,
  output axi_resp_e               s_axil_rresp_o,
  output logic                    s_axil_rvalid_o,
  input  logic                    s_axil_rready_i
);

  reg_req_s                req;
  logic                    req_v;
  logic                    req_ready_and;
  logic [`AXIL_DATA_W-1:0] rsp_data;
  logic                    rsp_v;
  logic                    rsp_ready_and;

  axil_fifo_client client_i (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_o           (req),
    .req_v_o         (req_v),
    .req_ready_and_i (req_ready_and),
    .rsp_data_i      (rsp_data),
    .rsp_v_i         (rsp_v),
    .rsp_ready_and_o (rsp_ready_and),
    .s_axil_awaddr_i (s_axil_awaddr_i),
    .s_axil_awprot_i (s_axil_awprot_i),
    .s_axil_awvalid_i(s_axil_awvalid_i),
    .s_axil_awready_o(s_axil_awready_o),
    .s_axil_wdata_i  (s_axil_wdata_i),
    .s_axil_wstrb_i  (s_axil_wstrb_i),
    .s_axil_wvalid_i (s_axil_wvalid_i),
    .s_axil_wready_o (s_axil_wready_o),
    .s_axil_bresp_o  (s_axil_bresp_o),
    .s_axil_bvalid_o (s_axil_bvalid_o),
    .s_axil_bready_i (s_axil_bready_i),
    .s_axil_araddr_i (s_axil_araddr_i),
    .s_axil_arprot_i (s_axil_arprot_i),
    .s_axil_arvalid_i(s_axil_arvalid_i),
    .s_axil_arready_o(s_axil_arready_o),
    .s_axil_rdata_o  (s_axil_rdata_o),
    .s_axil_rresp_o  (s_axil_rresp_o),
    .s_axil_rvalid_o (s_axil_rvalid_o),
    .s_axil_rready_i (s_axil_rready_i)
  );

  reg_bank bank_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .req_i          (req),
    .req_v_i        (req_v),
    .req_ready_and_o(req_ready_and),
    .rsp_data_o     (rsp_data),
    .rsp_v_o        (rsp_v),
    .rsp_ready_and_i(rsp_ready_and)
  );

endmodule

// File: dv/axil_reg_tb.sv
`timescale 1ns/10ps
`include "axil_reg_settings.svh"

module axil_reg_tb
  import axil_reg_pkg::*;
();

  localparam int timeout_cycles = 200;

  logic                    clk_i;
  logic                    reset_i;
  logic [`AXIL_ADDR_W-1:0] s_axil_awaddr_i;
  axi_prot_e               s_axil_awprot_i;
  logic                    s_axil_awvalid_i;
  logic                    s_axil_awready_o;
  logic [`AXIL_DATA_W-1:0] s_axil_wdata_i;
  logic [`AXIL_STRB_W-1:0] s_axil_wstrb_i;
  logic                    s_axil_wvalid_i;
  logic                    s_axil_wready_o;
  axi_resp_e               s_axil_bresp_o;
  logic                    s_axil_bvalid_o;
  logic                    s_axil_bready_i;
  logic [`AXIL_ADDR_W-1:0] s_axil_araddr_i;
  axi_prot_e               s_axil_arprot_i;
  logic                    s_axil_arvalid_i;
  logic                    s_axil_arready_o;
  logic [`AXIL_DATA_W-1:0] s_axil_rdata_o;
  axi_resp_e               s_axil_rresp_o;
  logic                    s_axil_rvalid_o;
  logic                    s_axil_rready_i;

  logic [`AXIL_DATA_W-1:0] model [`REG_COUNT];
  logic [`AXIL_DATA_W-1:0] exp_rdata_q [$];
  integer                  seed;
  int                      errors;
  int                      checks;
  int                      resp_seq;
  int                      r_seq;
  int                      b_seq;

  axil_reg_top dut_i (.*);

  always #20 clk_i = ~clk_i;

  // Expected read data with the word index wrapping modulo the bank size
  function automatic logic [`AXIL_DATA_W-1:0] exp_read(logic [`AXIL_ADDR_W-1:0] addr);
    return model[(addr / 4) % `REG_COUNT];
  endfunction

  task automatic model_write(logic [`AXIL_ADDR_W-1:0] addr, logic [`AXIL_DATA_W-1:0] data,
                             logic [`AXIL_STRB_W-1:0] strb);
    int idx;
    idx = (addr / 4) % `REG_COUNT;
    for (int b = 0; b < `AXIL_STRB_W; b++) begin
      if (strb[b]) begin
        model[idx][b*8 +: 8] = data[b*8 +: 8];
      end
    end
  endtask

  task automatic end_run();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  task automatic timed_out(string what);
    $display("Timeout: %s did not arrive within %0d cycles", what, timeout_cycles);
    errors++;
    end_run();
  endtask

  task automatic check_data(string name, logic [`AXIL_DATA_W-1:0] exp,
                            logic [`AXIL_DATA_W-1:0] act);
    checks++;
    if (act !== exp) begin
      $display("[ERROR] %s expected %h got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_resp(string name, axi_resp_e exp, axi_resp_e act);
    checks++;
    if (act !== exp) begin
      $display("[ERROR] %s expected %h got %h", name, exp, act);
      errors++;
    end
  endtask

  // Responses are checked at the handshake edge
  always @(posedge clk_i) begin
    if (!reset_i && s_axil_rvalid_o && s_axil_rready_i) begin
      if (exp_rdata_q.size() == 0) begin
        $display("Read response arrived with no read outstanding");
        errors++;
      end else begin
        check_data("s_axil_rdata_o", exp_rdata_q.pop_front(), s_axil_rdata_o);
      end
      check_resp("s_axil_rresp_o", e_resp_okay, s_axil_rresp_o);
      resp_seq++;
      r_seq = resp_seq;
    end
    if (!reset_i && s_axil_bvalid_o && s_axil_bready_i) begin
      check_resp("s_axil_bresp_o", e_resp_okay, s_axil_bresp_o);
      resp_seq++;
      b_seq = resp_seq;
    end
  end

  task automatic send_ar(logic [`AXIL_ADDR_W-1:0] addr, axi_prot_e prot);
    int waited;
    @(posedge clk_i);
    #2;
    s_axil_araddr_i  = addr;
    s_axil_arprot_i  = prot;
    s_axil_arvalid_i = 1'b1;
    waited = 0;
    @(posedge clk_i);
    while (!s_axil_arready_o) begin
      waited++;
      if (waited > timeout_cycles) timed_out("arready");
      @(posedge clk_i);
    end
    #2 s_axil_arvalid_i = 1'b0;
  endtask

  task automatic send_aw(logic [`AXIL_ADDR_W-1:0] addr, axi_prot_e prot);
    int waited;
    @(posedge clk_i);
    #2;
    s_axil_awaddr_i  = addr;
    s_axil_awprot_i  = prot;
    s_axil_awvalid_i = 1'b1;
    waited = 0;
    @(posedge clk_i);
    while (!s_axil_awready_o) begin
      waited++;
      if (waited > timeout_cycles) timed_out("awready");
      @(posedge clk_i);
    end
    #2 s_axil_awvalid_i = 1'b0;
  endtask

  task automatic send_w(logic [`AXIL_DATA_W-1:0] data, logic [`AXIL_STRB_W-1:0] strb);
    int waited;
    @(posedge clk_i);
    #2;
    s_axil_wdata_i  = data;
    s_axil_wstrb_i  = strb;
    s_axil_wvalid_i = 1'b1;
    waited = 0;
    @(posedge clk_i);
    while (!s_axil_wready_o) begin
      waited++;
      if (waited > timeout_cycles) timed_out("wready");
      @(posedge clk_i);
    end
    #2 s_axil_wvalid_i = 1'b0;
  endtask

  // Ready held low for a few cycles to stall the response
  task automatic wait_r(int stall);
    int waited;
    repeat (stall + 1) @(posedge clk_i);
    #2 s_axil_rready_i = 1'b1;
    waited = 0;
    @(posedge clk_i);
    while (!s_axil_rvalid_o) begin
      waited++;
      if (waited > timeout_cycles) timed_out("rvalid");
      @(posedge clk_i);
    end
    #2 s_axil_rready_i = 1'b0;
  endtask

  task automatic wait_b(int stall);
    int waited;
    repeat (stall + 1) @(posedge clk_i);
    #2 s_axil_bready_i = 1'b1;
    waited = 0;
    @(posedge clk_i);
    while (!s_axil_bvalid_o) begin
      waited++;
      if (waited > timeout_cycles) timed_out("bvalid");
      @(posedge clk_i);
    end
    #2 s_axil_bready_i = 1'b0;
  endtask

  task automatic axil_write(logic [`AXIL_ADDR_W-1:0] addr, logic [`AXIL_DATA_W-1:0] data,
                            logic [`AXIL_STRB_W-1:0] strb, int aw_gap, int w_gap, int stall);
    fork
      begin
        repeat (aw_gap) @(posedge clk_i);
        send_aw(addr, e_prot_data_sec_unpriv);
      end
      begin
        repeat (w_gap) @(posedge clk_i);
        send_w(data, strb);
      end
    join
    wait_b(stall);
    model_write(addr, data, strb);
  endtask

  task automatic axil_read(logic [`AXIL_ADDR_W-1:0] addr, int stall);
    exp_rdata_q.push_back(exp_read(addr));
    send_ar(addr, axi_prot_e'($random(seed) & 7));
    wait_r(stall);
  endtask

  task automatic report_test(string name, int errors_before);
    $display("Test %s finished with %0d errors", name, errors - errors_before);
  endtask

  initial begin
    int                      mark;
    logic [`AXIL_STRB_W-1:0] strbs [8];
    logic [`AXIL_ADDR_W-1:0] addr;
    logic [`AXIL_DATA_W-1:0] data;
    seed             = 32'h394ac844;
    errors           = 0;
    checks           = 0;
    resp_seq         = 0;
    r_seq            = 0;
    b_seq            = 0;
    strbs            = '{4'h1, 4'h2, 4'h4, 4'h8, 4'h3, 4'hc, 4'h5, 4'ha};
    clk_i            = 1'b0;
    reset_i          = 1'b1;
    s_axil_awaddr_i  = '0;
    s_axil_awprot_i  = e_prot_data_sec_unpriv;
    s_axil_awvalid_i = 1'b0;
    s_axil_wdata_i   = '0;
    s_axil_wstrb_i   = '0;
    s_axil_wvalid_i  = 1'b0;
    s_axil_bready_i  = 1'b0;
    s_axil_araddr_i  = '0;
    s_axil_arprot_i  = e_prot_data_sec_unpriv;
    s_axil_arvalid_i = 1'b0;
    s_axil_rready_i  = 1'b0;
    for (int i = 0; i < `REG_COUNT; i++) begin
      model[i] = '0;
    end
    repeat (5) @(posedge clk_i);
    #2 reset_i = 1'b0;

    mark = errors;
    for (int i = 0; i < `REG_COUNT; i++) axil_read(i * 4, 0);
    report_test("reset values", mark);

    mark = errors;
    for (int i = 0; i < `REG_COUNT; i++) axil_write(i * 4, $random(seed), 4'hf, 0, 0, 0);
    for (int i = 0; i < `REG_COUNT; i++) axil_read(i * 4, 0);
    report_test("full writes", mark);

    mark = errors;
    foreach (strbs[k]) begin
      axil_write(5 * 4, $random(seed), strbs[k], 0, 0, 0);
      axil_read(5 * 4, 0);
    end
    report_test("partial strobes", mark);

    // Byte offsets first, then addresses past the bank that wrap around
    mark = errors;
    for (int i = 0; i < `REG_COUNT; i++) axil_read(i * 4 + 1 + (i % 3), 0);
    for (int i = 0; i < `REG_COUNT; i++) axil_read(12'h040 * (1 + i % 4) + i * 4, 0);
    axil_write(12'h7c8, 32'hcafe_0123, 4'hf, 0, 0, 0);
    axil_read(12'h008, 0);
    report_test("unaligned and alias", mark);

    // All three channels in one cycle so the read sees the old value
    mark = errors;
    exp_rdata_q.push_back(exp_read(7 * 4));
    fork
      send_ar(7 * 4, e_prot_data_sec_unpriv);
      send_aw(7 * 4, e_prot_data_sec_unpriv);
      send_w(32'h5a5a_a5a5, 4'hf);
    join
    fork
      wait_r(0);
      wait_b(0);
    join
    if (r_seq > b_seq) begin
      $display("Read response came after the write response on the same register");
      errors++;
    end
    model_write(7 * 4, 32'h5a5a_a5a5, 4'hf);
    axil_read(7 * 4, 0);
    report_test("read priority", mark);

    mark = errors;
    for (int n = 0; n < 200; n++) begin
      addr = $random(seed);
      data = $random(seed);
      if ($random(seed) & 1) begin
        axil_write(addr, data, $random(seed), $random(seed) & 3, $random(seed) & 3,
                   $random(seed) & 3);
      end else begin
        axil_read(addr, $random(seed) & 3);
      end
    end
    report_test("random traffic", mark);

    end_run();
  end

endmodule

// File: sources.f
+incdir+logic
logic/axil_reg_pkg.sv
logic/one_slot_fifo.sv
logic/axil_fifo_client.sv
logic/reg_bank.sv
logic/axil_reg_top.sv
dv/axil_reg_tb.sv
